//--- rs_config.svh
// Table size, tag, data, multiplier and result queue macros
`ifndef RS_CONFIG_SVH
`define RS_CONFIG_SVH

//////////////////////////////
// Reservation table
//////////////////////////////

// Rows in the reservation station
`define RS_SIZE 8

// Tag width, 32 physical tags
`define TAG_W 5

// Operand and result width
`define DATA_W 16

//////////////////////////////
// Execute and result path
//////////////////////////////

// Multiplier pipeline depth
`define MUL_STAGES 3

// Result queue entries, power of two
`define RQ_DEPTH 4

`endif

//--- rs_pkg.sv
// Opcode, unit and handshake enums plus the reservation row struct
`include "rs_config.svh"

package rs_pkg;

	//////////////////////////////
	// Enums
	//////////////////////////////

	// LI takes the immediate and no sources
	typedef enum logic [2:0] {
		LI  = 3'd0,
		ADD = 3'd1,
		SUB = 3'd2,
		AND = 3'd3,
		XOR = 3'd4,
		MUL = 3'd5
	} opcode_t;

	typedef enum logic {
		FU_ALU = 1'b0,
		FU_MUL = 1'b1
	} fu_t;

	// Shared by the dispatch slave and the result master
	typedef enum logic [1:0] {
		IDLE     = 2'd0,
		ACK      = 2'd1,
		WAIT_LOW = 2'd2
	} hs_state_t;

	//////////////////////////////
	// Reservation row
	//////////////////////////////

	typedef struct packed {
		logic               busy;
		opcode_t            op;
		fu_t                fu;
		logic [`TAG_W-1:0]  dest;
		logic               src1_ready;
		logic [`TAG_W-1:0]  src1_tag;
		logic [`DATA_W-1:0] src1_val;
		logic               src2_ready;
		logic [`TAG_W-1:0]  src2_tag;
		logic [`DATA_W-1:0] src2_val;
	} rs_row_t;

endpackage

//--- rs_ifc.sv
// Issue path and common data bus interfaces with their modports
`include "rs_config.svh"

// Table to execute, one lane per unit type
interface issue_if import rs_pkg::*; ();
	logic    alu_valid;
	rs_row_t alu_row;
	logic    alu_stall;
	logic    mul_valid;
	rs_row_t mul_row;
	logic    mul_stall;

	modport table_side (
		output alu_valid, alu_row, mul_valid, mul_row,
		input  alu_stall, mul_stall
	);

	modport execute (
		input  alu_valid, alu_row, mul_valid, mul_row,
		output alu_stall, mul_stall
	);
endinterface

// Result broadcast, a transfer is valid and ready together
interface cdb_if ();
	logic               valid;
	logic               ready;
	logic [`TAG_W-1:0]  tag;
	logic [`DATA_W-1:0] value;

	modport source (output valid, tag, value, input ready);

	modport sink (input valid, tag, value, output ready);

	// Snoopers see only accepted transfers
	modport monitor (input valid, ready, tag, value);
endinterface

//--- dispatch_decode.sv
// Dispatch handshake slave, tag register file, source bypass and row build
`include "rs_config.svh"

module dispatch_decode import rs_pkg::*; (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     disp_req,
	input  opcode_t                  disp_op,
	input  logic [`TAG_W-1:0]        disp_dest,
	input  logic [`TAG_W-1:0]        disp_src1,
	input  logic [`TAG_W-1:0]        disp_src2,
	input  logic [`DATA_W-1:0]       disp_imm,
	output logic                     disp_ack,
	output logic                     wr_en,
	output rs_row_t                  wr_row,
	input  logic [$clog2(`RS_SIZE):0] free_cnt,
	cdb_if.monitor                   cdb
);
	localparam int NUM_TAGS = 1 << `TAG_W;

	hs_state_t          state;
	logic [NUM_TAGS-1:0] tag_ready;
	logic [`DATA_W-1:0] tag_val [NUM_TAGS];
	logic               cdb_fire;
	logic               byp1;
	logic               byp2;

	assign cdb_fire = cdb.valid && cdb.ready;

	// Row enters on the same edge that raises ack
	assign wr_en = (state == IDLE) && disp_req && (free_cnt != '0);

	// Source broadcast this cycle counts as ready
	assign byp1 = cdb_fire && (cdb.tag == disp_src1);
	assign byp2 = cdb_fire && (cdb.tag == disp_src2);

	always_comb begin
		wr_row = '0;
		wr_row.busy = 1'b1;
		wr_row.op = disp_op;
		wr_row.fu = (disp_op == MUL) ? FU_MUL : FU_ALU;
		wr_row.dest = disp_dest;
		wr_row.src1_tag = disp_src1;
		wr_row.src2_tag = disp_src2;
		if (disp_op == LI) begin
			wr_row.src1_ready = 1'b1;
			wr_row.src1_val = disp_imm;
			wr_row.src2_ready = 1'b1;
		end else begin
			wr_row.src1_ready = tag_ready[disp_src1] || byp1;
			wr_row.src1_val = byp1 ? cdb.value : tag_val[disp_src1];
			wr_row.src2_ready = tag_ready[disp_src2] || byp2;
			wr_row.src2_val = byp2 ? cdb.value : tag_val[disp_src2];
		end
	end

	//////////////////////////////
	// Four-phase slave
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= IDLE;
			disp_ack <= 1'b0;
		end else begin
			case (state)
				IDLE: if (wr_en) begin
					disp_ack <= 1'b1;
					state <= ACK;
				end
				ACK: if (!disp_req) begin
					disp_ack <= 1'b0;
					state <= WAIT_LOW;
				end
				// Master needs a cycle to see ack low
				default: if (!disp_req) state <= IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Tag register file
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			tag_ready <= '1;
			for (int t = 0; t < NUM_TAGS; t++) begin
				tag_val[t] <= '0;
			end
		end else begin
			if (cdb_fire) begin
				tag_ready[cdb.tag] <= 1'b1;
				tag_val[cdb.tag] <= cdb.value;
			end
			// New producer makes its tag pending
			if (wr_en) tag_ready[disp_dest] <= 1'b0;
		end
	end

	// Ack only answers a request seen with room in the table
	a_ack_on_req: assert property (@(posedge clock) disable iff (!rst_n)
		$rose(disp_ack) |-> $past(disp_req && (free_cnt != '0)));

endmodule

//--- rs_table.sv
// Reservation rows, CDB wakeup, lowest-index issue select and row allocation
`include "rs_config.svh"

module rs_table import rs_pkg::*; (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      wr_en,
	input  rs_row_t                   wr_row,
	output logic [$clog2(`RS_SIZE):0] free_cnt,
	issue_if.table_side               iss,
	cdb_if.monitor                    cdb
);
	localparam int IDX_W = $clog2(`RS_SIZE);

	rs_row_t            rows [`RS_SIZE];
	logic [`RS_SIZE-1:0] alu_req;
	logic [`RS_SIZE-1:0] mul_req;
	logic [IDX_W-1:0]   alu_idx;
	logic [IDX_W-1:0]   mul_idx;
	logic [IDX_W-1:0]   free_idx;
	logic               cdb_fire;

	assign cdb_fire = cdb.valid && cdb.ready;

	//////////////////////////////
	// Ready rows per unit type
	always_comb begin
		for (int i = 0; i < `RS_SIZE; i++) begin
			alu_req[i] = rows[i].busy && rows[i].src1_ready && rows[i].src2_ready
				&& (rows[i].fu == FU_ALU);
			mul_req[i] = rows[i].busy && rows[i].src1_ready && rows[i].src2_ready
				&& (rows[i].fu == FU_MUL);
		end
	end

	// Scan downward so the lowest index wins
	always_comb begin
		alu_idx = '0;
		mul_idx = '0;
		free_idx = '0;
		free_cnt = '0;
		for (int i = `RS_SIZE - 1; i >= 0; i--) begin
			if (alu_req[i]) alu_idx = IDX_W'(i);
			if (mul_req[i]) mul_idx = IDX_W'(i);
			if (!rows[i].busy) begin
				free_idx = IDX_W'(i);
				free_cnt = free_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Issue
	always_comb begin
		iss.alu_valid = (|alu_req) && !iss.alu_stall;
		iss.alu_row = rows[alu_idx];
		iss.mul_valid = (|mul_req) && !iss.mul_stall;
		iss.mul_row = rows[mul_idx];
	end

	//////////////////////////////
	// Row update
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `RS_SIZE; i++) begin
				rows[i].busy <= 1'b0;
			end
		end else begin
			// Wakeup, ready takes effect next cycle
			for (int i = 0; i < `RS_SIZE; i++) begin
				if (cdb_fire && rows[i].busy && !rows[i].src1_ready
					&& (rows[i].src1_tag == cdb.tag)) begin
					rows[i].src1_ready <= 1'b1;
					rows[i].src1_val <= cdb.value;
				end
				if (cdb_fire && rows[i].busy && !rows[i].src2_ready
					&& (rows[i].src2_tag == cdb.tag)) begin
					rows[i].src2_ready <= 1'b1;
					rows[i].src2_val <= cdb.value;
				end
			end
			if (iss.alu_valid) rows[alu_idx].busy <= 1'b0;
			if (iss.mul_valid) rows[mul_idx].busy <= 1'b0;
			// Free row, so never the one being issued
			if (wr_en) rows[free_idx] <= wr_row;
		end
	end

	// Selected row is a waiting complete row
	a_alu_issue: assert property (@(posedge clock) disable iff (!rst_n)
		iss.alu_valid |-> iss.alu_row.busy
			&& iss.alu_row.src1_ready && iss.alu_row.src2_ready);

	a_mul_issue: assert property (@(posedge clock) disable iff (!rst_n)
		iss.mul_valid |-> iss.mul_row.busy
			&& iss.mul_row.src1_ready && iss.mul_row.src2_ready);

endmodule

//--- fu_execute.sv
// ALU output register, multiplier pipeline and CDB arbitration
`include "rs_config.svh"

module fu_execute import rs_pkg::*; (
	input  logic  clock,
	input  logic  rst_n,
	issue_if.execute iss,
	cdb_if.source    cdb
);
	localparam int LAST = `MUL_STAGES - 1;

	logic                   alu_v;
	logic [`TAG_W-1:0]      alu_tag;
	logic [`DATA_W-1:0]     alu_val;
	logic [`DATA_W-1:0]     alu_res;
	logic [`MUL_STAGES-1:0] mul_v;
	logic [`TAG_W-1:0]      mul_tag [`MUL_STAGES];
	logic [`DATA_W-1:0]     mul_val [`MUL_STAGES];
	logic [`DATA_W-1:0]     mul_lo;
	logic                   mul_out_v;

	//////////////////////////////
	// ALU
	always_comb begin
		case (iss.alu_row.op)
			LI:      alu_res = iss.alu_row.src1_val;
			ADD:     alu_res = iss.alu_row.src1_val + iss.alu_row.src2_val;
			SUB:     alu_res = iss.alu_row.src1_val - iss.alu_row.src2_val;
			AND:     alu_res = iss.alu_row.src1_val & iss.alu_row.src2_val;
			XOR:     alu_res = iss.alu_row.src1_val ^ iss.alu_row.src2_val;
			default: alu_res = '0;
		endcase
	end

	// Low half of the product only
	assign mul_lo = iss.mul_row.src1_val * iss.mul_row.src2_val;

	assign mul_out_v = mul_v[LAST];

	//////////////////////////////
	// CDB, multiplier has priority
	assign cdb.valid = mul_out_v || alu_v;
	assign cdb.tag = mul_out_v ? mul_tag[LAST] : alu_tag;
	assign cdb.value = mul_out_v ? mul_val[LAST] : alu_val;

	// Queue full freezes both units
	assign iss.mul_stall = !cdb.ready;
	assign iss.alu_stall = !cdb.ready || (alu_v && mul_out_v);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			alu_v <= 1'b0;
			mul_v <= '0;
		end else begin
			if (!iss.alu_stall) alu_v <= iss.alu_valid;
			if (cdb.ready) begin
				for (int s = LAST; s > 0; s--) begin
					mul_v[s] <= mul_v[s-1];
				end
				mul_v[0] <= iss.mul_valid;
			end
		end
	end

	// Tag travels with each stage
	always_ff @(posedge clock) begin
		if (!iss.alu_stall) begin
			alu_tag <= iss.alu_row.dest;
			alu_val <= alu_res;
		end
		if (cdb.ready) begin
			for (int s = LAST; s > 0; s--) begin
				mul_tag[s] <= mul_tag[s-1];
				mul_val[s] <= mul_val[s-1];
			end
			mul_tag[0] <= iss.mul_row.dest;
			mul_val[0] <= mul_lo;
		end
	end

endmodule

//--- result_port.sv
// Result queue and four-phase result master
`include "rs_config.svh"

module result_port import rs_pkg::*; (
	input  logic               clock,
	input  logic               rst_n,
	cdb_if.sink                cdb,
	output logic               res_req,
	output logic [`TAG_W-1:0]  res_tag,
	output logic [`DATA_W-1:0] res_value,
	input  logic               res_ack
);
	localparam int PTR_W = $clog2(`RQ_DEPTH);
	localparam logic [PTR_W:0] FULL = `RQ_DEPTH;

	logic [`TAG_W-1:0]  q_tag [`RQ_DEPTH];
	logic [`DATA_W-1:0] q_val [`RQ_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [PTR_W:0]     count;
	hs_state_t          state;
	logic               push;
	logic               pop;

	assign cdb.ready = (count != FULL);
	assign push = cdb.valid && cdb.ready;
	// Pop as req drops
	assign pop = (state == ACK) && res_ack;

	// Head stays put while req is high
	assign res_tag = q_tag[rd_ptr];
	assign res_value = q_val[rd_ptr];

	always_ff @(posedge clock) begin
		if (push) begin
			q_tag[wr_ptr] <= cdb.tag;
			q_val[wr_ptr] <= cdb.value;
		end
	end

	// Pointers wrap on their own at a power of two
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			state <= IDLE;
			res_req <= 1'b0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop) count <= count + 1'b1;
			else if (pop && !push) count <= count - 1'b1;
			case (state)
				IDLE: if (count != '0) begin
					res_req <= 1'b1;
					state <= ACK;
				end
				ACK: if (res_ack) begin
					res_req <= 1'b0;
					state <= WAIT_LOW;
				end
				default: if (!res_ack) state <= IDLE;
			endcase
		end
	end

	a_no_push_full: assert property (@(posedge clock) disable iff (!rst_n)
		(count == FULL) |-> !push);

	// A refused result stays on the bus unchanged
	a_cdb_hold: assert property (@(posedge clock) disable iff (!rst_n)
		(cdb.valid && !cdb.ready) |=> cdb.valid && $stable(cdb.tag) && $stable(cdb.value));

endmodule

//--- rs_top.sv
// Top level joining decode, reservation table, execute and result port
`include "rs_config.svh"

module rs_top import rs_pkg::*; (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               disp_req,
	input  opcode_t            disp_op,
	input  logic [`TAG_W-1:0]  disp_dest,
	input  logic [`TAG_W-1:0]  disp_src1,
	input  logic [`TAG_W-1:0]  disp_src2,
	input  logic [`DATA_W-1:0] disp_imm,
	output logic               disp_ack,
	output logic               res_req,
	output logic [`TAG_W-1:0]  res_tag,
	output logic [`DATA_W-1:0] res_value,
	input  logic               res_ack
);
	logic                      wr_en;
	rs_row_t                   wr_row;
	logic [$clog2(`RS_SIZE):0] free_cnt;

	issue_if i_iss ();
	cdb_if   i_cdb ();

	dispatch_decode i_decode (
		.clock, .rst_n, .disp_req, .disp_op, .disp_dest, .disp_src1, .disp_src2,
		.disp_imm, .disp_ack, .wr_en, .wr_row, .free_cnt, .cdb(i_cdb)
	);

	rs_table i_table (
		.clock, .rst_n, .wr_en, .wr_row, .free_cnt, .iss(i_iss), .cdb(i_cdb)
	);

	fu_execute i_execute (
		.clock, .rst_n, .iss(i_iss), .cdb(i_cdb)
	);

	result_port i_result (
		.clock, .rst_n, .cdb(i_cdb), .res_req, .res_tag, .res_value, .res_ack
	);

endmodule

//--- tb_rs.sv
// Testbench with clock, reset, dispatch driver, reference model, result compare and report
`include "rs_config.svh"

module tb_rs import rs_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	logic               clock;
	logic               rst_n;
	logic               disp_req;
	opcode_t            disp_op;
	logic [`TAG_W-1:0]  disp_dest;
	logic [`TAG_W-1:0]  disp_src1;
	logic [`TAG_W-1:0]  disp_src2;
	logic [`DATA_W-1:0] disp_imm;
	logic               disp_ack;
	logic               res_req;
	logic [`TAG_W-1:0]  res_tag;
	logic [`DATA_W-1:0] res_value;
	logic               res_ack;

	// Mirror of the tag values and the set of tags still in flight
	logic [`DATA_W-1:0] exp_val [32];
	bit                 pending [32];
	int                 out_cnt = 0;
	int                 errors = 0;
	int                 err_mark = 0;
	int                 checks = 0;
	int                 tests = 0;
	bit                 hold_ack = 1'b0;
	int unsigned        max_gap = 0;
	// Destination picked by the latest dispatch
	logic [`TAG_W-1:0]  last_dest;

	rs_top i_dut (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	//////////////////////////////
	// Reference and checks
	//////////////////////////////

	function automatic logic [`DATA_W-1:0] ref_result(input opcode_t op,
			input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b,
			input logic [`DATA_W-1:0] imm);
		case (op)
			LI:      return imm;
			ADD:     return a + b;
			SUB:     return a - b;
			AND:     return a & b;
			XOR:     return a ^ b;
			MUL:     return a * b;
			default: return '0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic take_result(input logic [`TAG_W-1:0] tag, input logic [`DATA_W-1:0] val);
		if (!pending[tag]) begin
			errors++;
			$display("Result for tag %0d arrived with no instruction in flight", tag);
		end else begin
			check_value("res_value", 32'(val), 32'(exp_val[tag]));
			pending[tag] = 1'b0;
			out_cnt--;
		end
	endtask

	// Free destination tag, scanned from a random start
	function automatic logic [`TAG_W-1:0] pick_dest();
		int start;
		start = $urandom_range(31, 0);
		for (int i = 0; i < 32; i++) begin
			if (!pending[(start + i) % 32]) return `TAG_W'((start + i) % 32);
		end
		return `TAG_W'(start);
	endfunction

	//////////////////////////////
	// Dispatch driver
	//////////////////////////////

	task automatic dispatch(input opcode_t op, input logic [`TAG_W-1:0] s1,
			input logic [`TAG_W-1:0] s2, input logic [`DATA_W-1:0] imm,
			input int limit, input bit must, output bit accepted);
		logic [`TAG_W-1:0]  dest;
		logic [`DATA_W-1:0] old_val;
		int                 n;
		dest = pick_dest();
		last_dest = dest;
		old_val = exp_val[dest];
		exp_val[dest] = ref_result(op, exp_val[s1], exp_val[s2], imm);
		pending[dest] = 1'b1;
		out_cnt++;
		@(posedge clock);
		disp_op <= op;
		disp_dest <= dest;
		disp_src1 <= s1;
		disp_src2 <= s2;
		disp_imm <= imm;
		disp_req <= 1'b1;
		n = 0;
		do begin
			@(posedge clock);
			n++;
		end while (!disp_ack && n < limit);
		accepted = disp_ack;
		disp_req <= 1'b0;
		// Ack may rise on the edge that drops the request
		if (!accepted) begin
			@(posedge clock);
			accepted = disp_ack;
		end
		if (!accepted) begin
			pending[dest] = 1'b0;
			out_cnt--;
			exp_val[dest] = old_val;
			if (must) begin
				errors++;
				$display("Dispatch of tag %0d was never acknowledged", dest);
			end
		end
		n = 0;
		while (disp_ack && n < limit) begin
			@(posedge clock);
			n++;
		end
		if (disp_ack) begin
			errors++;
			$display("Dispatch ack stayed high after the request dropped");
		end
	endtask

	task automatic send(input opcode_t op, input logic [`TAG_W-1:0] s1,
			input logic [`TAG_W-1:0] s2, input logic [`DATA_W-1:0] imm);
		bit ok;
		dispatch(op, s1, s2, imm, 200, 1'b1, ok);
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (out_cnt != 0 && n < 4000) begin
			@(posedge clock);
			n++;
		end
		if (out_cnt != 0) begin
			errors++;
			$display("Timed out with %0d results never returned", out_cnt);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("Test %0d %s: %0d errors", tests, name, errors - err_mark);
		err_mark = errors;
	endtask

	//////////////////////////////
	// Result consumer and compare
	initial begin : consumer
		int unsigned gap;
		gap = 0;
		forever begin
			@(posedge clock);
			if (res_ack) begin
				if (!res_req) res_ack <= 1'b0;
			end else if (res_req && !hold_ack) begin
				if (gap == 0) begin
					take_result(res_tag, res_value);
					res_ack <= 1'b1;
					gap = $urandom_range(max_gap, 0);
				end else begin
					gap--;
				end
			end
		end
	end

	//////////////////////////////
	// Main sequence
	initial begin : main
		bit                ok;
		int                taken;
		logic [`TAG_W-1:0] tag_a;
		logic [`TAG_W-1:0] tag_b;
		logic [`TAG_W-1:0] tag_c;
		void'($urandom(32'h09e6d524));
		rst_n = 1'b0;
		disp_req = 1'b0;
		disp_op = LI;
		disp_dest = '0;
		disp_src1 = '0;
		disp_src2 = '0;
		disp_imm = '0;
		res_ack = 1'b0;
		for (int t = 0; t < 32; t++) begin
			exp_val[t] = '0;
			pending[t] = 1'b0;
		end
		repeat (3) @(posedge clock);
		rst_n <= 1'b1;
		@(posedge clock);

		// Independent ALU operations on loaded values
		check_value("disp_ack", 32'(disp_ack), 0);
		check_value("res_req", 32'(res_req), 0);
		send(LI, 0, 0, 16'h1234);
		tag_a = last_dest;
		send(LI, 0, 0, 16'h0f0f);
		tag_b = last_dest;
		send(ADD, tag_a, tag_b, 16'h0);
		send(SUB, tag_a, tag_b, 16'h0);
		send(AND, tag_a, tag_b, 16'h0);
		send(XOR, tag_a, tag_b, 16'h0);
		drain();
		end_test("independent alu ops");

		// Chain through the multiplier
		send(LI, 0, 0, 16'h0007);
		tag_a = last_dest;
		send(MUL, tag_a, tag_a, 16'h0);
		tag_b = last_dest;
		send(ADD, tag_b, tag_a, 16'h0);
		tag_c = last_dest;
		send(ADD, tag_c, tag_b, 16'h0);
		drain();
		end_test("dependency chain");

		// Fill every stage with results held back
		hold_ack = 1'b1;
		taken = 0;
		ok = 1'b1;
		while (ok && taken < 24) begin
			dispatch((taken % 2) ? MUL : LI, `TAG_W'($urandom_range(31, 0)),
				`TAG_W'($urandom_range(31, 0)), 16'($urandom), 30, 1'b0, ok);
			if (ok) taken++;
		end
		if (taken > `RS_SIZE + `RQ_DEPTH + `MUL_STAGES + 1
			|| taken < `RS_SIZE + `RQ_DEPTH) begin
			errors++;
			$display("Back-pressure did not stop dispatch as expected after %0d", taken);
		end
		hold_ack = 1'b0;
		drain();
		end_test("full back-pressure");

		// Back to back multiplies and ALU ops
		max_gap = 3;
		for (int i = 0; i < 24; i++) begin
			send((i % 2) ? MUL : opcode_t'($urandom_range(4, 0)),
				`TAG_W'($urandom_range(31, 0)), `TAG_W'($urandom_range(31, 0)),
				16'($urandom));
		end
		drain();
		end_test("back to back issue");

		// Random mix with dependencies
		max_gap = 4;
		for (int i = 0; i < 200; i++) begin
			send(opcode_t'($urandom_range(5, 0)), `TAG_W'($urandom_range(31, 0)),
				`TAG_W'($urandom_range(31, 0)), 16'($urandom));
		end
		drain();
		check_value("out_cnt", out_cnt, 0);
		end_test("random mix");

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- sim.f
+incdir+.
rs_pkg.sv
rs_ifc.sv
dispatch_decode.sv
rs_table.sv
fu_execute.sv
result_port.sv
rs_top.sv
tb_rs.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and decide from the log

verilator --binary --timing --assert -f sim.f --top-module tb_rs -o tb_rs \
	> build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_rs > sim.log 2>&1
cat sim.log

grep -q "Result: PASSED" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
